// ==== design/dac_cfg.svh ====
`ifndef DAC_CFG_SVH
`define DAC_CFG_SVH

// lane and sample widths
`define DAC_LANE_W 8
`define DAC_SAMPLE_W 16

// index widths, ifft index is zero-extended to the training one
`define DAC_IFFT_IDX_W 8
`define DAC_TRAIN_IDX_W 9

// 512 beats of storage
`define DAC_FIFO_AW 9

`define DAC_SYNC_STAGES 2

`endif

// ==== design/dac_pkg.sv ====
`include "dac_cfg.svh"

package dac_pkg;

  // two lanes, added lane by lane at the frame boundary
  typedef struct packed {
    logic [`DAC_LANE_W-1:0] hi;
    logic [`DAC_LANE_W-1:0] lo;
  } sample_t;

  typedef logic [`DAC_TRAIN_IDX_W-1:0] index_t;

  // one fifo word
  typedef struct packed {
    sample_t data;
    logic    last;
    index_t  index;
  } beat_t;

endpackage

// ==== design/dac_stream_if.sv ====
interface dac_stream_if;

  logic            valid;
  logic            ready;
  dac_pkg::beat_t  beat;

  // transfer when valid and ready are both high at the clock edge
  modport src (
    output valid,
    output beat,
    input  ready
  );

  modport snk (
    input  valid,
    input  beat,
    output ready
  );

endinterface

// ==== design/config_arm.sv ====
`include "dac_cfg.svh"

module config_arm (
  input  logic clk2,
  input  logic rstN1,
  input  logic mcu_config,
  input  logic frame_done,
  output logic config_armed
);

  logic [`DAC_SYNC_STAGES-1:0] sync_q;
  logic                        sync_out;

  assign sync_out = sync_q[`DAC_SYNC_STAGES-1];

  always_ff @(posedge clk2 or negedge rstN1) begin
    if (!rstN1) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`DAC_SYNC_STAGES-2:0], mcu_config};  // mcu strobe in at bit 0
    end
  end

  // set wins over clear
  always_ff @(posedge clk2 or negedge rstN1) begin
    if (!rstN1) begin
      config_armed <= 1'b0;
    end else if (sync_out) begin
      config_armed <= 1'b1;
    end else if (frame_done) begin
      config_armed <= 1'b0;
    end
  end

  // strobe must have passed the whole chain plus the flag
  a_arm_from_sync : assert property (
    @(posedge clk2) disable iff (!rstN1)
    $rose(config_armed) |-> $past(mcu_config, `DAC_SYNC_STAGES + 1)
  );

endmodule

// ==== design/frame_merger.sv ====
`include "dac_cfg.svh"

module frame_merger (
  input  logic                        clk2,
  input  logic                        rstN1,
  input  dac_pkg::sample_t            train_data,
  input  logic                        train_vld,
  input  logic                        train_last,
  input  dac_pkg::index_t             train_index,
  output logic                        train_rdy,
  input  dac_pkg::sample_t            ifft_data,
  input  logic                        ifft_vld,
  input  logic                        ifft_last,
  input  logic [`DAC_IFFT_IDX_W-1:0]  ifft_index,
  output logic                        ifft_rdy,
  input  logic                        armed,
  dac_stream_if.src                   merged
);

  typedef enum logic {
    PH_TRAIN,
    PH_IFFT
  } phase_e;

  phase_e           phase_q;
  logic             first_q;   // next ifft beat is the overlap beat
  dac_pkg::sample_t held_q;    // last training sample, not sent alone
  dac_pkg::sample_t sum;
  logic             train_fire;
  logic             ifft_fire;

  // lane-wise, each lane wraps on its own
  assign sum.hi = ifft_data.hi + held_q.hi;
  assign sum.lo = ifft_data.lo + held_q.lo;

  assign train_rdy = (phase_q == PH_TRAIN) && armed && merged.ready;
  assign ifft_rdy  = (phase_q == PH_IFFT) && merged.ready;

  assign train_fire = train_vld && train_rdy;
  assign ifft_fire  = ifft_vld && ifft_rdy;

  always_comb begin
    if (phase_q == PH_TRAIN) begin
      merged.valid      = train_vld && armed && !train_last;  // last one is held back
      merged.beat.data  = train_data;
      merged.beat.last  = 1'b0;
      merged.beat.index = train_index;
    end else begin
      merged.valid      = ifft_vld;
      merged.beat.data  = first_q ? sum : ifft_data;
      merged.beat.last  = ifft_last;
      merged.beat.index = {{(`DAC_TRAIN_IDX_W - `DAC_IFFT_IDX_W){1'b0}}, ifft_index};
    end
  end

  always_ff @(posedge clk2 or negedge rstN1) begin
    if (!rstN1) begin
      phase_q <= PH_TRAIN;
      first_q <= 1'b0;
    end else if (train_fire && train_last) begin
      phase_q <= PH_IFFT;
      first_q <= 1'b1;
    end else if (ifft_fire) begin
      first_q <= 1'b0;
      if (ifft_last) begin
        phase_q <= PH_TRAIN;
      end
    end
  end

  always_ff @(posedge clk2) begin
    if (train_fire && train_last) begin
      held_q <= train_data;
    end
  end

  a_one_input : assert property (
    @(posedge clk2) disable iff (!rstN1)
    !(train_rdy && ifft_rdy)
  );

endmodule

// ==== design/sample_fifo.sv ====
`include "dac_cfg.svh"

module sample_fifo (
  input  logic      clk2,
  input  logic      rstN1,
  dac_stream_if.snk wr,
  dac_stream_if.src rd
);

  localparam int unsigned AW = `DAC_FIFO_AW;
  localparam logic [AW:0] DEPTH = 1 << AW;

  dac_pkg::beat_t mem [0:DEPTH-1];

  logic [AW-1:0]  wr_ptr_q;
  logic [AW-1:0]  rd_ptr_q;
  logic [AW:0]    count_q;     // entries in memory, output reg not counted
  logic           out_vld_q;
  dac_pkg::beat_t out_beat_q;
  logic           full;
  logic           wr_fire;
  logic           load;

  assign full    = (count_q == DEPTH);
  assign wr.ready = !full;
  assign wr_fire = wr.valid && !full;

  // prefetch when output stage is empty or draining
  assign load = (count_q != '0) && (!out_vld_q || rd.ready);

  assign rd.valid = out_vld_q;
  assign rd.beat  = out_beat_q;

  always_ff @(posedge clk2) begin
    if (wr_fire) begin
      mem[wr_ptr_q] <= wr.beat;
    end
  end

  always_ff @(posedge clk2) begin
    if (load) begin
      out_beat_q <= mem[rd_ptr_q];
    end
  end

  always_ff @(posedge clk2 or negedge rstN1) begin
    if (!rstN1) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      out_vld_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (load) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_fire, load})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      if (load) begin
        out_vld_q <= 1'b1;
      end else if (rd.ready) begin
        out_vld_q <= 1'b0;
      end
    end
  end

  // write pointer must not move while full
  a_no_write_full : assert property (
    @(posedge clk2) disable iff (!rstN1)
    full |=> wr_ptr_q == $past(wr_ptr_q)
  );

  a_count_range : assert property (
    @(posedge clk2) disable iff (!rstN1)
    count_q <= DEPTH
  );

endmodule

// ==== design/dac_frame_tx.sv ====
`include "dac_cfg.svh"

module dac_frame_tx (
  input  logic                         clk2,
  input  logic                         rstN1,
  // training stream
  input  logic [`DAC_SAMPLE_W-1:0]     dac_train_din,
  input  logic                         dac_train_din_vld,
  input  logic                         dac_train_din_last,
  input  logic [`DAC_TRAIN_IDX_W-1:0]  dac_train_din_index,
  output logic                         dac_train_dout_rdy,
  // ifft stream
  input  logic [`DAC_SAMPLE_W-1:0]     dac_ifft_din,
  input  logic                         dac_ifft_din_vld,
  input  logic                         dac_ifft_din_last,
  input  logic [`DAC_IFFT_IDX_W-1:0]   dac_ifft_din_index,
  output logic                         dac_ifft_dout_rdy,
  // dac side
  input  logic                         dac_din_rdy,
  output logic [`DAC_SAMPLE_W-1:0]     dac_dout,
  output logic                         dac_dout_vld,
  output logic                         dac_dout_last,
  output logic [`DAC_TRAIN_IDX_W-1:0]  dac_dout_index,
  input  logic                         mcu_config,
  output logic                         config_armed
);

  dac_stream_if merged ();
  dac_stream_if tx ();

  config_arm config_arm_inst (
    .clk2         (clk2),
    .rstN1        (rstN1),
    .mcu_config   (mcu_config),
    .frame_done   (tx.valid && tx.ready && tx.beat.last),  // last beat leaves
    .config_armed (config_armed)
  );

  frame_merger frame_merger_inst (
    .clk2        (clk2),
    .rstN1       (rstN1),
    .train_data  (dac_train_din),
    .train_vld   (dac_train_din_vld),
    .train_last  (dac_train_din_last),
    .train_index (dac_train_din_index),
    .train_rdy   (dac_train_dout_rdy),
    .ifft_data   (dac_ifft_din),
    .ifft_vld    (dac_ifft_din_vld),
    .ifft_last   (dac_ifft_din_last),
    .ifft_index  (dac_ifft_din_index),
    .ifft_rdy    (dac_ifft_dout_rdy),
    .armed       (config_armed),
    .merged      (merged.src)
  );

  sample_fifo sample_fifo_inst (
    .clk2  (clk2),
    .rstN1 (rstN1),
    .wr    (merged.snk),
    .rd    (tx.src)
  );

  assign tx.ready       = dac_din_rdy;
  assign dac_dout       = tx.beat.data;
  assign dac_dout_vld   = tx.valid;
  assign dac_dout_last  = tx.beat.last;
  assign dac_dout_index = tx.beat.index;

endmodule

// ==== bench/tb_dac_frame_tx.sv ====
`include "dac_cfg.svh"

module tb_dac_frame_tx;

  localparam int WAIT_LIMIT = 2000;

  logic                         clk2;
  logic                         rstN1;
  logic [`DAC_SAMPLE_W-1:0]     dac_train_din;
  logic                         dac_train_din_vld;
  logic                         dac_train_din_last;
  logic [`DAC_TRAIN_IDX_W-1:0]  dac_train_din_index;
  logic                         dac_train_dout_rdy;
  logic [`DAC_SAMPLE_W-1:0]     dac_ifft_din;
  logic                         dac_ifft_din_vld;
  logic                         dac_ifft_din_last;
  logic [`DAC_IFFT_IDX_W-1:0]   dac_ifft_din_index;
  logic                         dac_ifft_dout_rdy;
  logic                         dac_din_rdy;
  logic [`DAC_SAMPLE_W-1:0]     dac_dout;
  logic                         dac_dout_vld;
  logic                         dac_dout_last;
  logic [`DAC_TRAIN_IDX_W-1:0]  dac_dout_index;
  logic                         mcu_config;
  logic                         config_armed;

  logic [31:0] lfsr_state = 32'd82970;
  logic        rdy_pattern [0:1023];
  bit          rdy_random;
  string       test_name;
  int          mismatches;
  int          failures;

  // current frame, filled by make_frame
  logic [15:0] tr_data [$];
  logic [8:0]  tr_idx [$];
  int          tr_gap [$];
  logic [15:0] if_data [$];
  logic [7:0]  if_idx [$];
  int          if_gap [$];
  logic [25:0] exp_q [$];     // {data, last, index}
  logic [15:0] out_data [$];

  dac_frame_tx dac_frame_tx_inst (.*);

  initial begin
    clk2 = 1'b0;
    forever #5 clk2 = ~clk2;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      mismatches++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // reference model of the assembled frame
  function automatic void build_expected();
    int          n;
    int          m;
    int          hi;
    int          lo;
    logic [15:0] s;
    n = tr_data.size();
    m = if_data.size();
    exp_q.delete();
    for (int i = 0; i < n - 1; i++) begin
      exp_q.push_back({tr_data[i], 1'b0, tr_idx[i]});
    end
    hi = (int'(tr_data[n-1][15:8]) + int'(if_data[0][15:8])) % 256;
    lo = (int'(tr_data[n-1][7:0]) + int'(if_data[0][7:0])) % 256;
    s  = {hi[7:0], lo[7:0]};
    exp_q.push_back({s, (m == 1), 1'b0, if_idx[0]});  // boundary sample
    for (int i = 1; i < m; i++) begin
      exp_q.push_back({if_data[i], (i == m - 1), 1'b0, if_idx[i]});
    end
  endfunction

  task automatic make_frame(input int n, input int m, input bit gaps);
    tr_data.delete();
    tr_idx.delete();
    tr_gap.delete();
    if_data.delete();
    if_idx.delete();
    if_gap.delete();
    for (int i = 0; i < n; i++) begin
      tr_data.push_back(rand_bits(16));
      tr_idx.push_back(9'(256 + i));
      tr_gap.push_back(gaps ? int'(rand_bits(2)) : 0);
    end
    for (int i = 0; i < m; i++) begin
      if_data.push_back(rand_bits(16));
      if_idx.push_back(8'(192 + i));  // msb set to catch a missing zero-extend
      if_gap.push_back(gaps ? int'(rand_bits(2)) : 0);
    end
  endtask

  task automatic arm_assembler();
    int n;
    mcu_config = 1'b1;
    @(negedge clk2);
    mcu_config = 1'b0;
    n = 0;
    while (!config_armed && n < WAIT_LIMIT) begin
      @(negedge clk2);
      n++;
    end
    if (!config_armed) begin
      failures++;
      $display("config_armed did not rise after a config pulse in %s", test_name);
    end
  endtask

  task automatic drive_training();
    int n;
    for (int i = 0; i < tr_data.size(); i++) begin
      repeat (tr_gap[i]) @(negedge clk2);
      dac_train_din       = tr_data[i];
      dac_train_din_index = tr_idx[i];
      dac_train_din_last  = (i == tr_data.size() - 1);
      dac_train_din_vld   = 1'b1;
      n = 0;
      while (!dac_train_dout_rdy && n < WAIT_LIMIT) begin
        check_value("ifft_rdy_in_training", 0, dac_ifft_dout_rdy);
        @(negedge clk2);
        n++;
      end
      check_value("ifft_rdy_in_training", 0, dac_ifft_dout_rdy);
      if (!dac_train_dout_rdy) begin
        failures++;
        $display("training beat %0d was never accepted in %s", i, test_name);
        dac_train_din_vld = 1'b0;
        return;
      end
      @(negedge clk2);  // taken at the edge in between
      dac_train_din_vld = 1'b0;
    end
  endtask

  task automatic drive_ifft();
    int n;
    for (int i = 0; i < if_data.size(); i++) begin
      repeat (if_gap[i]) @(negedge clk2);
      dac_ifft_din       = if_data[i];
      dac_ifft_din_index = if_idx[i];
      dac_ifft_din_last  = (i == if_data.size() - 1);
      dac_ifft_din_vld   = 1'b1;
      n = 0;
      while (!dac_ifft_dout_rdy && n < WAIT_LIMIT) begin
        check_value("train_rdy_in_ifft", 0, dac_train_dout_rdy);
        @(negedge clk2);
        n++;
      end
      check_value("train_rdy_in_ifft", 0, dac_train_dout_rdy);
      if (!dac_ifft_dout_rdy) begin
        failures++;
        $display("ifft beat %0d was never accepted in %s", i, test_name);
        dac_ifft_din_vld = 1'b0;
        return;
      end
      @(negedge clk2);
      dac_ifft_din_vld = 1'b0;
    end
  endtask

  // armed drops only after the last beat leaves
  task automatic wait_drained();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || config_armed) && n < WAIT_LIMIT) begin
      @(negedge clk2);
      n++;
    end
    if (exp_q.size() != 0 || config_armed) begin
      failures++;
      $display("frame in %s did not finish, %0d beats still missing", test_name, exp_q.size());
    end
  endtask

  task automatic run_frame(input bit arm);
    build_expected();
    out_data.delete();
    if (arm) begin
      arm_assembler();
    end
    drive_training();
    drive_ifft();
    wait_drained();
  endtask

  // output side, drives dac_din_rdy and compares each transfer
  initial begin
    int k;
    k = 0;
    dac_din_rdy = 1'b0;
    forever begin
      @(negedge clk2);
      dac_din_rdy = rdy_random ? rdy_pattern[k % 1024] : 1'b1;
      k++;
      if (dac_dout_vld && dac_din_rdy) begin
        if (exp_q.size() == 0) begin
          failures++;
          $display("output beat %h came out with nothing expected in %s", dac_dout, test_name);
        end else begin
          check_value(test_name, exp_q.pop_front(), {dac_dout, dac_dout_last, dac_dout_index});
        end
        if (dac_dout_last) begin
          check_value("armed_at_last", 1, config_armed);  // still armed until last leaves
        end
        out_data.push_back(dac_dout);
      end
    end
  end

  initial begin
    int cycles;
    rstN1               = 1'b0;
    dac_train_din       = '0;
    dac_train_din_vld   = 1'b0;
    dac_train_din_last  = 1'b0;
    dac_train_din_index = '0;
    dac_ifft_din        = '0;
    dac_ifft_din_vld    = 1'b0;
    dac_ifft_din_last   = 1'b0;
    dac_ifft_din_index  = '0;
    mcu_config          = 1'b0;
    rdy_random          = 1'b0;
    mismatches          = 0;
    failures            = 0;
    test_name           = "reset";
    for (int i = 0; i < 1024; i++) begin
      rdy_pattern[i] = 1'(rand_bits(1));
    end
    repeat (10) @(negedge clk2);
    rstN1 = 1'b1;
    @(negedge clk2);

    check_value("reset_state", 0,
                {dac_dout_vld, dac_train_dout_rdy, dac_ifft_dout_rdy, config_armed});
    mcu_config = 1'b1;
    cycles = 0;
    while (!config_armed && cycles < WAIT_LIMIT) begin
      @(negedge clk2);
      cycles++;
      mcu_config = 1'b0;
    end
    check_value("arm_latency", 3, cycles);

    test_name = "single_frame";
    make_frame(6, 8, 1'b0);
    run_frame(1'b0);

    test_name = "lane_wrap";
    make_frame(5, 4, 1'b0);
    tr_data[4] = 16'hF0C8;  // both lanes overflow
    if_data[0] = 16'h305A;
    run_frame(1'b1);
    check_value("lane_wrap_sum", 32'h2022, (out_data.size() > 4) ? out_data[4] : 'x);

    test_name  = "random_frames";
    rdy_random = 1'b1;
    for (int f = 0; f < 4; f++) begin
      make_frame(1 + int'(rand_bits(3)), 1 + int'(rand_bits(4)), 1'b1);
      run_frame(1'b1);
    end

    test_name = "disarm_stall";
    check_value("disarmed", 0, {config_armed, dac_train_dout_rdy});
    make_frame(3, 3, 1'b1);
    tr_gap[0]           = 0;
    dac_train_din       = tr_data[0];
    dac_train_din_index = tr_idx[0];
    dac_train_din_last  = 1'b0;
    dac_train_din_vld   = 1'b1;
    repeat (40) begin
      @(negedge clk2);
      check_value("stall", 0, {dac_train_dout_rdy, dac_dout_vld});
    end
    run_frame(1'b1);

    $display("mismatches: %0d, other failures: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+design
design/dac_pkg.sv
design/dac_stream_if.sv
design/config_arm.sv
design/frame_merger.sv
design/sample_fifo.sv
design/dac_frame_tx.sv
bench/tb_dac_frame_tx.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_dac_frame_tx
FILELIST := list.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS     := $(wildcard design/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
